// ==== dv/issue_cases.txt ====
# name pairs inst0 inst1 load_valid load_dest first_latency ev0_slot0 ev0_slot1 ev1_slot0 ev1_slot1
# instructions and ids in hex, the rest decimal; id 0 means nothing issued on that slot
# add r3,r1,r2 = 04221800  add r6,r4,r5 = 04853000  add r6,r3,r5 = 04653000
# lw r7,(r1) = 80270000  sw r8,(r2) = 84480000  jump = c0000000  cmp r3,r1,r2 = 20221800
alu_pair        1 04221800 04853000 0 0 1 1 2 0 0
branch_then_alu 1 c0000000 04853000 0 0 1 2 1 0 0
alu_then_load   1 04221800 80270000 0 0 1 2 1 0 0
cmp_then_store  1 20221800 84480000 0 0 1 2 1 0 0
mem_mem         1 80270000 84480000 0 0 1 1 0 2 0
split_raw       1 04221800 04653000 0 0 1 1 0 2 0
load_use_src0   1 04221800 04853000 1 1 2 1 2 0 0
load_use_src1   1 04221800 04853000 1 5 2 1 2 0 0
load_no_match   1 04221800 04853000 1 9 1 1 2 0 0
back_to_back    2 04221800 04853000 0 0 1 1 2 3 4

// ==== build.f ====
logic/issue_pkg.sv
logic/reg_decode.sv
logic/issue_queue.sv
logic/hazard_check.sv
logic/steer_unit.sv
logic/issue_stage.sv
dv/issue_checker.sv
dv/issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the issue stage testbench with Verilator; pass only if the log says so.
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module issue_tb -f build.f \
  -o issue_sim && ./obj_dir/issue_sim > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -qx "Test completed successfully" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== dv/issue_tb.sv ====
`timescale 1ns/1ps

module issue_tb
  import issue_pkg::*;
();

  localparam int clk_period   = 8;
  localparam int reset_cycles = 5;
  localparam int case_cycles  = 10; // watchdog budget per case.
  localparam int max_cases    = 32;

  logic     clk;
  logic     reset;
  logic     flush;
  logic     push_valid;
  addr_t    pc0, pc1;
  inst_t    inst0, inst1;
  inst_id_t id0, id1;
  logic     push_ready;
  logic     ex_load_valid;
  reg_idx_t ex_load_dest;
  logic     issue0_valid, issue1_valid;
  addr_t    issue0_pc, issue1_pc;
  inst_t    issue0_inst, issue1_inst;
  inst_id_t issue0_id, issue1_id;

  string case_name     [max_cases];
  int    case_pairs    [max_cases];
  inst_t case_inst0    [max_cases];
  inst_t case_inst1    [max_cases];
  int    case_ld_valid [max_cases];
  int    case_ld_dest  [max_cases];
  int    case_lat      [max_cases];
  int    case_exp      [max_cases][4];
  int    n_cases = 0;
  int    bad_lines = 0;

  always #(clk_period / 2) clk = ~clk;

  issue_stage #(
    .QUEUE_DEPTH (4)
  ) u_issue_stage (
    .clk           (clk),
    .reset         (reset),
    .flush         (flush),
    .push_valid    (push_valid),
    .pc0           (pc0),
    .inst0         (inst0),
    .id0           (id0),
    .pc1           (pc1),
    .inst1         (inst1),
    .id1           (id1),
    .push_ready    (push_ready),
    .ex_load_valid (ex_load_valid),
    .ex_load_dest  (ex_load_dest),
    .issue0_valid  (issue0_valid),
    .issue0_pc     (issue0_pc),
    .issue0_inst   (issue0_inst),
    .issue0_id     (issue0_id),
    .issue1_valid  (issue1_valid),
    .issue1_pc     (issue1_pc),
    .issue1_inst   (issue1_inst),
    .issue1_id     (issue1_id)
  );

  issue_checker u_checker (
    .clk          (clk),
    .push_ready   (push_ready),
    .issue0_valid (issue0_valid),
    .issue0_pc    (issue0_pc),
    .issue0_inst  (issue0_inst),
    .issue0_id    (issue0_id),
    .issue1_valid (issue1_valid),
    .issue1_pc    (issue1_pc),
    .issue1_inst  (issue1_inst),
    .issue1_id    (issue1_id)
  );

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    string       name;
    int          pairs, ldv, ldd, lat, e0, e1, e2, e3;
    logic [31:0] i0, i1;
    fd = $fopen("dv/issue_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/issue_cases.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %d %h %h %d %d %d %h %h %h %h",
                    name, pairs, i0, i1, ldv, ldd, lat, e0, e1, e2, e3);
        if (n == 11 && n_cases < max_cases) begin
          case_name[n_cases]     = name;
          case_pairs[n_cases]    = pairs;
          case_inst0[n_cases]    = i0;
          case_inst1[n_cases]    = i1;
          case_ld_valid[n_cases] = ldv;
          case_ld_dest[n_cases]  = ldd;
          case_lat[n_cases]      = lat;
          case_exp[n_cases][0]   = e0;
          case_exp[n_cases][1]   = e1;
          case_exp[n_cases][2]   = e2;
          case_exp[n_cases][3]   = e3;
          n_cases = n_cases + 1;
        end else if (n > 0) begin
          $display("unreadable case line: %s", line);
          bad_lines = bad_lines + 1;
        end
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // stimulus, all on the falling edge
  //////////////////////////////////////////////////

  task automatic push_pair(input int k, input inst_t a, input inst_t b);
    push_valid = 1'b1;
    pc0        = 32'h1000 + 32'(8 * k);
    pc1        = pc0 + 32'd4;
    inst0      = a;
    inst1      = b;
    id0        = inst_id_t'(2 * k + 1);
    id1        = inst_id_t'(2 * k + 2);
    while (!push_ready) begin
      @(negedge clk);
    end
    @(negedge clk); // taken on the edge in between.
    push_valid = 1'b0;
  endtask

  task automatic run_case(input int c);
    flush = 1'b1;
    push_pair(0, case_inst0[c], case_inst1[c]); // refused, flush comes first.
    flush = 1'b0;
    u_checker.begin_case(case_name[c], case_inst0[c], case_inst1[c], case_lat[c],
                         case_exp[c][0], case_exp[c][1], case_exp[c][2], case_exp[c][3]);
    push_pair(0, case_inst0[c], case_inst1[c]);
    ex_load_valid = (case_ld_valid[c] != 0);
    ex_load_dest  = reg_idx_t'(case_ld_dest[c]);
    if (case_pairs[c] > 1) begin
      push_pair(1, case_inst0[c], case_inst1[c]);
    end else begin
      @(negedge clk);
    end
    ex_load_valid = 1'b0;
    ex_load_dest  = '0;
    repeat (6) @(negedge clk);
    u_checker.end_case();
  endtask

  initial begin
    int c;
    clk           = 1'b0;
    reset         = 1'b1;
    flush         = 1'b0;
    push_valid    = 1'b0;
    pc0           = '0;
    pc1           = '0;
    inst0         = '0;
    inst1         = '0;
    id0           = '0;
    id1           = '0;
    ex_load_valid = 1'b0;
    ex_load_dest  = '0;
    load_cases();
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    u_checker.check_idle("reset");
    for (c = 0; c < n_cases; c++) begin
      run_case(c);
    end
    if (n_cases == 0) begin
      $display("no test cases were read");
    end
    $display("%0d cases: %0d passed, %0d failed, %0d other errors", n_cases,
             u_checker.pass_count, u_checker.fail_count, u_checker.stray_errors + bad_lines);
    if (n_cases > 0 && u_checker.fail_count == 0 && u_checker.stray_errors == 0 &&
        bad_lines == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog.
  initial begin
    int limit_ns;
    wait (n_cases > 0);
    limit_ns = (n_cases * case_cycles + reset_cycles + 2) * clk_period;
    #(limit_ns);
    $display("watchdog: run still busy after %0d ns", limit_ns);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== dv/issue_checker.sv ====
`timescale 1ns/1ps

module issue_checker
  import issue_pkg::*;
(
  input logic     clk,
  input logic     push_ready,
  input logic     issue0_valid,
  input addr_t    issue0_pc,
  input inst_t    issue0_inst,
  input inst_id_t issue0_id,
  input logic     issue1_valid,
  input addr_t    issue1_pc,
  input inst_t    issue1_inst,
  input inst_id_t issue1_id
);

  localparam int max_events = 4;

  int    pass_count = 0;
  int    fail_count = 0;
  int    stray_errors = 0; // outside any case.
  logic  active = 1'b0;
  int    edge_count;
  int    n_events;
  int    first_lat;
  int    case_errors;
  int    exp_lat;
  int    exp0 [2];
  int    exp1 [2];
  int    got0 [max_events];
  int    got1 [max_events];
  addr_t got_pc0   [max_events];
  addr_t got_pc1   [max_events];
  inst_t got_inst0 [max_events];
  inst_t got_inst1 [max_events];
  inst_t pushed_older;
  inst_t pushed_younger;
  string case_name;

  always @(posedge clk) begin
    if (active) begin
      edge_count = edge_count + 1;
    end
  end

  // issue outputs are registered, steady at the falling edge.
  always @(negedge clk) begin
    if (active && (issue0_valid || issue1_valid)) begin
      if (n_events == 0) begin
        first_lat = edge_count - 1; // edge 1 takes the pair.
      end
      if (n_events < max_events) begin
        got0[n_events]      = issue0_valid ? int'(issue0_id) : 0;
        got1[n_events]      = issue1_valid ? int'(issue1_id) : 0;
        got_pc0[n_events]   = issue0_pc;
        got_inst0[n_events] = issue0_inst;
        got_pc1[n_events]   = issue1_pc;
        got_inst1[n_events] = issue1_inst;
      end
      n_events = n_events + 1;
    end
  end

  // pair k holds ids 2k+1 and 2k+2 at 0x1000 + 8k and the word after.
  function automatic addr_t pc_of_id(input int id);
    return 32'h1000 + addr_t'(4 * (id - 1));
  endfunction

  function automatic inst_t inst_of_id(input int id);
    return (id % 2 == 1) ? pushed_older : pushed_younger;
  endfunction

  function automatic int idle_errors(input string when);
    int errs;
    errs = 0;
    if (!push_ready) begin
      $display("push_ready is low after %s", when);
      errs = errs + 1;
    end
    if (issue0_valid || issue1_valid) begin
      $display("an issue valid is high after %s", when);
      errs = errs + 1;
    end
    return errs;
  endfunction

  task automatic check_idle(input string when);
    stray_errors = stray_errors + idle_errors(when);
  endtask

  task automatic begin_case(input string name, input inst_t older, input inst_t younger,
                            input int lat, input int e00, input int e01,
                            input int e10, input int e11);
    case_name      = name;
    pushed_older   = older;
    pushed_younger = younger;
    exp_lat        = lat;
    exp0[0]        = e00;
    exp1[0]        = e01;
    exp0[1]        = e10;
    exp1[1]        = e11;
    case_errors    = idle_errors({"flush in ", name});
    n_events       = 0;
    edge_count     = 0;
    first_lat      = 0;
    active         = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // compare the recorded events
  //////////////////////////////////////////////////

  task automatic check_slot(input int slot, input int ev, input int exp_id, input int got_id,
                            input addr_t got_pc, input inst_t got_inst);
    if (got_id != exp_id) begin
      $display("[FAIL] %s event %0d issue%0d_id expected 0x%0h got 0x%0h",
               case_name, ev, slot, exp_id, got_id);
      case_errors = case_errors + 1;
    end else if (exp_id != 0) begin
      if (got_pc != pc_of_id(exp_id)) begin
        $display("[FAIL] %s event %0d issue%0d_pc expected 0x%0h got 0x%0h",
                 case_name, ev, slot, pc_of_id(exp_id), got_pc);
        case_errors = case_errors + 1;
      end
      if (got_inst != inst_of_id(exp_id)) begin
        $display("[FAIL] %s event %0d issue%0d_inst expected 0x%0h got 0x%0h",
                 case_name, ev, slot, inst_of_id(exp_id), got_inst);
        case_errors = case_errors + 1;
      end
    end
  endtask

  task automatic end_case();
    int i;
    int n_exp;
    int n_cmp;
    active = 1'b0;
    n_exp  = 0;
    for (i = 0; i < 2; i++) begin
      if (exp0[i] != 0 || exp1[i] != 0) begin
        n_exp = n_exp + 1;
      end
    end
    n_cmp = (n_events < n_exp) ? n_events : n_exp;
    for (i = 0; i < n_cmp; i++) begin
      check_slot(0, i, exp0[i], got0[i], got_pc0[i], got_inst0[i]);
      check_slot(1, i, exp1[i], got1[i], got_pc1[i], got_inst1[i]);
    end
    if (n_events < n_exp) begin
      $display("%s: only %0d of %0d expected issue events were seen", case_name, n_events, n_exp);
      case_errors = case_errors + 1;
    end
    if (n_events > n_exp) begin
      $display("%s: %0d issue events seen where %0d were expected", case_name, n_events, n_exp);
      case_errors = case_errors + 1;
    end
    if (n_events > 0 && first_lat != exp_lat) begin
      $display("%s: first issue came %0d cycles after the push instead of %0d",
               case_name, first_lat, exp_lat);
      case_errors = case_errors + 1;
    end
    if (case_errors == 0) begin
      pass_count = pass_count + 1;
      $display("PASS %s", case_name);
    end else begin
      fail_count = fail_count + 1;
      $display("FAIL %s", case_name);
    end
  endtask

endmodule

// ==== logic/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage
  import issue_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     flush,
  input  logic     push_valid,
  input  addr_t    pc0,
  input  inst_t    inst0,
  input  inst_id_t id0,
  input  addr_t    pc1,
  input  inst_t    inst1,
  input  inst_id_t id1,
  output logic     push_ready,
  input  logic     ex_load_valid,
  input  reg_idx_t ex_load_dest,
  output logic     issue0_valid,
  output addr_t    issue0_pc,
  output inst_t    issue0_inst,
  output inst_id_t issue0_id,
  output logic     issue1_valid,
  output addr_t    issue1_pc,
  output inst_t    issue1_inst,
  output inst_id_t issue1_id
);

  logic [1:0] head_valid;
  addr_t      head_pc0, head_pc1;
  inst_t      head_inst0, head_inst1;
  inst_id_t   head_id0, head_id1;
  logic [1:0] cand_mask;
  logic [1:0] pop_count;

  issue_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_issue_queue (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .push_valid (push_valid),
    .pc0        (pc0),
    .inst0      (inst0),
    .id0        (id0),
    .pc1        (pc1),
    .inst1      (inst1),
    .id1        (id1),
    .pop_count  (pop_count),
    .push_ready (push_ready),
    .head_valid (head_valid),
    .head_pc0   (head_pc0),
    .head_inst0 (head_inst0),
    .head_id0   (head_id0),
    .head_pc1   (head_pc1),
    .head_inst1 (head_inst1),
    .head_id1   (head_id1)
  );

  hazard_check u_hazard_check (
    .head_valid    (head_valid),
    .head_inst0    (head_inst0),
    .head_inst1    (head_inst1),
    .ex_load_valid (ex_load_valid),
    .ex_load_dest  (ex_load_dest),
    .cand_mask     (cand_mask)
  );

  steer_unit u_steer_unit (
    .clk          (clk),
    .reset        (reset),
    .flush        (flush),
    .cand_mask    (cand_mask),
    .head_pc0     (head_pc0),
    .head_inst0   (head_inst0),
    .head_id0     (head_id0),
    .head_pc1     (head_pc1),
    .head_inst1   (head_inst1),
    .head_id1     (head_id1),
    .pop_count    (pop_count),
    .issue0_valid (issue0_valid),
    .issue0_pc    (issue0_pc),
    .issue0_inst  (issue0_inst),
    .issue0_id    (issue0_id),
    .issue1_valid (issue1_valid),
    .issue1_pc    (issue1_pc),
    .issue1_inst  (issue1_inst),
    .issue1_id    (issue1_id)
  );

endmodule

// ==== logic/steer_unit.sv ====
`timescale 1ns/1ps

module steer_unit
  import issue_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       flush,
  input  logic [1:0] cand_mask,
  input  addr_t      head_pc0,
  input  inst_t      head_inst0,
  input  inst_id_t   head_id0,
  input  addr_t      head_pc1,
  input  inst_t      head_inst1,
  input  inst_id_t   head_id1,
  output logic [1:0] pop_count,
  output logic       issue0_valid,
  output addr_t      issue0_pc,
  output inst_t      issue0_inst,
  output inst_id_t   issue0_id,
  output logic       issue1_valid,
  output addr_t      issue1_pc,
  output inst_t      issue1_inst,
  output inst_id_t   issue1_id
);

  pipe_class_e cls0, cls1;
  logic        both_fit;
  logic        take0, take1;
  logic        older_on_1;

  function automatic pipe_class_e pipe_of(input inst_t inst);
    opcode_t     op;
    pipe_class_e cls;
    op  = inst[op_msb:op_lsb];
    cls = pipe_any;
    if (op == op_cmp || op == op_test || op == op_cmpi || op == op_testi) begin
      cls = pipe_branch; // flags feed the branch pipe.
    end else if (op[5:4] == cls_mem) begin
      cls = pipe_mem;
    end else if (op[5:4] == cls_jump) begin
      cls = pipe_branch;
    end
    return cls;
  endfunction

  //////////////////////////////////////////////////
  // slot choice
  //////////////////////////////////////////////////

  always_comb begin
    cls0       = pipe_of(head_inst0);
    cls1       = pipe_of(head_inst1);
    both_fit   = !(cls0 == cls1 && cls0 != pipe_any);
    take0      = cand_mask[0];
    take1      = cand_mask[0] && cand_mask[1] && both_fit; // oldest first.
    older_on_1 = (cls0 == pipe_branch) ||
                 (take1 && cls0 == pipe_any && cls1 == pipe_mem);
    pop_count  = take1 ? 2'd2 : (take0 ? 2'd1 : 2'd0);
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      issue0_valid <= 1'b0;
      issue1_valid <= 1'b0;
    end else begin
      issue0_valid <= older_on_1 ? take1 : take0;
      issue1_valid <= older_on_1 ? take0 : take1;
    end
  end

  always_ff @(posedge clk) begin
    issue0_pc   <= older_on_1 ? head_pc1   : head_pc0;
    issue0_inst <= older_on_1 ? head_inst1 : head_inst0;
    issue0_id   <= older_on_1 ? head_id1   : head_id0;
    issue1_pc   <= older_on_1 ? head_pc0   : head_pc1;
    issue1_inst <= older_on_1 ? head_inst0 : head_inst1;
    issue1_id   <= older_on_1 ? head_id0   : head_id1;
  end

  a_slot_class: assert property (@(posedge clk) disable iff (reset)
    (!issue0_valid || pipe_of(issue0_inst) != pipe_branch) &&
    (!issue1_valid || pipe_of(issue1_inst) != pipe_mem))
    else $error("steer_unit: instruction issued on a pipe of the wrong class");

endmodule

// ==== logic/hazard_check.sv ====
`timescale 1ns/1ps

module hazard_check
  import issue_pkg::*;
(
  input  logic [1:0] head_valid,
  input  inst_t      head_inst0,
  input  inst_t      head_inst1,
  input  logic       ex_load_valid,
  input  reg_idx_t   ex_load_dest,
  output logic [1:0] cand_mask
);

  reg_idx_t src0_0, src1_0, dest_0;
  reg_idx_t src0_1, src1_1;
  logic     src0_valid_0, src1_valid_0, dest_valid_0;
  logic     src0_valid_1, src1_valid_1;
  logic     load_hit;
  logic     split_hit;

  function automatic logic reads_reg(input reg_idx_t s0, input logic s0_valid,
                                     input reg_idx_t s1, input logic s1_valid,
                                     input reg_idx_t r);
    return (s0_valid && s0 == r) || (s1_valid && s1 == r);
  endfunction

  reg_decode u_dec0 (
    .inst       (head_inst0),
    .src0       (src0_0),
    .src0_valid (src0_valid_0),
    .src1       (src1_0),
    .src1_valid (src1_valid_0),
    .dest       (dest_0),
    .dest_valid (dest_valid_0)
  );

  reg_decode u_dec1 (
    .inst       (head_inst1),
    .src0       (src0_1),
    .src0_valid (src0_valid_1),
    .src1       (src1_1),
    .src1_valid (src1_valid_1),
    .dest       (),
    .dest_valid ()
  );

  //////////////////////////////////////////////////
  // load-use and split checks
  //////////////////////////////////////////////////

  assign load_hit = ex_load_valid &&
    ((head_valid[0] && reads_reg(src0_0, src0_valid_0, src1_0, src1_valid_0, ex_load_dest)) ||
     (head_valid[1] && reads_reg(src0_1, src0_valid_1, src1_1, src1_valid_1, ex_load_dest)));

  // younger reads what the older writes.
  assign split_hit = dest_valid_0 &&
                     reads_reg(src0_1, src0_valid_1, src1_1, src1_valid_1, dest_0);

  assign cand_mask = load_hit ? 2'b00 : {head_valid[1] && !split_hit, head_valid[0]};

endmodule

// ==== logic/issue_queue.sv ====
`timescale 1ns/1ps

module issue_queue
  import issue_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       flush,
  input  logic       push_valid,
  input  addr_t      pc0,
  input  inst_t      inst0,
  input  inst_id_t   id0,
  input  addr_t      pc1,
  input  inst_t      inst1,
  input  inst_id_t   id1,
  input  logic [1:0] pop_count,
  output logic       push_ready,
  output logic [1:0] head_valid,
  output addr_t      head_pc0,
  output inst_t      head_inst0,
  output inst_id_t   head_id0,
  output addr_t      head_pc1,
  output inst_t      head_inst1,
  output inst_id_t   head_id1
);

  localparam int ptr_w = $clog2(QUEUE_DEPTH);
  localparam int cnt_w = $clog2(QUEUE_DEPTH + 1);

  if (QUEUE_DEPTH < 4 || (QUEUE_DEPTH % 2) != 0) begin : g_bad_depth
    $error("issue_queue: QUEUE_DEPTH must be even and at least 4");
  end

  addr_t    pc_mem   [QUEUE_DEPTH];
  inst_t    inst_mem [QUEUE_DEPTH];
  inst_id_t id_mem   [QUEUE_DEPTH];

  logic [ptr_w-1:0] rd_ptr, wr_ptr;
  logic [ptr_w-1:0] rd_ptr_p1, wr_ptr_p1;
  logic [cnt_w-1:0] count;
  logic             push_fire;

  function automatic logic [ptr_w-1:0] wrap_add(input logic [ptr_w-1:0] ptr,
                                                input logic [1:0] step);
    logic [ptr_w:0] sum;
    sum = {1'b0, ptr} + {{(ptr_w - 1){1'b0}}, step};
    if (sum >= (ptr_w + 1)'(QUEUE_DEPTH)) begin
      sum = sum - (ptr_w + 1)'(QUEUE_DEPTH);
    end
    return sum[ptr_w-1:0];
  endfunction

  assign rd_ptr_p1  = wrap_add(rd_ptr, 2'd1);
  assign wr_ptr_p1  = wrap_add(wr_ptr, 2'd1);
  assign push_ready = (count <= cnt_w'(QUEUE_DEPTH - 2)); // room for a pair.
  assign push_fire  = push_valid && push_ready && !flush;
  assign head_valid = {count >= cnt_w'(2), count >= cnt_w'(1)};

  assign head_pc0   = pc_mem[rd_ptr];
  assign head_inst0 = inst_mem[rd_ptr];
  assign head_id0   = id_mem[rd_ptr];
  assign head_pc1   = pc_mem[rd_ptr_p1];
  assign head_inst1 = inst_mem[rd_ptr_p1];
  assign head_id1   = id_mem[rd_ptr_p1];

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= wrap_add(wr_ptr, 2'd2);
      end
      rd_ptr <= wrap_add(rd_ptr, pop_count);
      count  <= count + (push_fire ? cnt_w'(2) : '0) - cnt_w'(pop_count);
    end
  end

  // wr_ptr stays even, so a pair never splits across the wrap.
  always_ff @(posedge clk) begin
    if (push_fire) begin
      pc_mem[wr_ptr]      <= pc0;
      inst_mem[wr_ptr]    <= inst0;
      id_mem[wr_ptr]      <= id0;
      pc_mem[wr_ptr_p1]   <= pc1;
      inst_mem[wr_ptr_p1] <= inst1;
      id_mem[wr_ptr_p1]   <= id1;
    end
  end

  a_pop_within_count: assert property (@(posedge clk) disable iff (reset)
    cnt_w'(pop_count) <= count)
    else $error("issue_queue: pop of %0d with only %0d entries", pop_count, count);

  // a pair may only land in free slots.
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    count <= cnt_w'(QUEUE_DEPTH))
    else $error("issue_queue: pair taken without room, count is %0d", count);

endmodule

// ==== logic/reg_decode.sv ====
`timescale 1ns/1ps

module reg_decode
  import issue_pkg::*;
(
  input  inst_t    inst,
  output reg_idx_t src0,
  output logic     src0_valid,
  output reg_idx_t src1,
  output logic     src1_valid,
  output reg_idx_t dest,
  output logic     dest_valid
);

  opcode_t opcode;

  assign opcode = inst[op_msb:op_lsb];

  always_comb begin
    src0       = inst[rs_msb:rs_lsb];
    src1       = inst[rt_msb:rt_lsb];
    dest       = inst[rd_msb:rd_lsb];
    src0_valid = 1'b0;
    src1_valid = 1'b0;
    dest_valid = 1'b0;
    if (opcode == op_jr) begin
      src0_valid = 1'b1;
    end else if (opcode != op_nop) begin
      case (opcode[5:4])
        cls_reg_alu: begin
          src0_valid = 1'b1;
          src1_valid = 1'b1;
          dest_valid = 1'b1;
        end
        cls_imm_alu: begin
          src0_valid = 1'b1;
          dest       = inst[rt_msb:rt_lsb]; // immediate form writes rt.
          dest_valid = 1'b1;
        end
        cls_mem: begin
          src0_valid = (opcode == op_lw) || (opcode == op_sw);
          src1_valid = (opcode == op_sw);  // store data.
          dest       = inst[rt_msb:rt_lsb];
          dest_valid = (opcode == op_lw);
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== logic/issue_pkg.sv ====
package issue_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  typedef logic [31:0] inst_t;
  typedef logic [31:0] addr_t;
  typedef logic [5:0]  inst_id_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [5:0]  opcode_t;

  //////////////////////////////////////////////////
  // instruction fields
  //////////////////////////////////////////////////

  localparam int op_msb = 31;
  localparam int op_lsb = 26;
  localparam int rs_msb = 25;
  localparam int rs_lsb = 21;
  localparam int rt_msb = 20;
  localparam int rt_lsb = 16;
  localparam int rd_msb = 15;
  localparam int rd_lsb = 11;

  // opcode class, top two opcode bits.
  localparam logic [1:0] cls_reg_alu = 2'b00;
  localparam logic [1:0] cls_imm_alu = 2'b01;
  localparam logic [1:0] cls_mem     = 2'b10;
  localparam logic [1:0] cls_jump    = 2'b11;

  //////////////////////////////////////////////////
  // opcodes
  //////////////////////////////////////////////////

  localparam opcode_t op_nop   = 6'b000000;
  localparam opcode_t op_cmp   = 6'b001000; // register alu, feeds branch.
  localparam opcode_t op_test  = 6'b001001;
  localparam opcode_t op_cmpi  = 6'b011000; // immediate alu, feeds branch.
  localparam opcode_t op_testi = 6'b011001;
  localparam opcode_t op_lw    = 6'b100000;
  localparam opcode_t op_sw    = 6'b100001;
  localparam opcode_t op_jr    = 6'b110010; // only jump with a source.

  // execute pipe an instruction needs.
  typedef enum logic [1:0] {
    pipe_any,
    pipe_mem,
    pipe_branch
  } pipe_class_e;

endpackage
